// ==== design/bus_pkg.sv ====
// ######################################
// Bus widths and the request and
// response structs of the host bus
// ######################################

`default_nettype none

package bus_pkg;

  localparam int AddrWidth = 32;
  localparam int DataWidth = 32;
  localparam int BeWidth   = DataWidth / 8;

  // Request as presented by the host, valid while req is high
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 we;
    logic [BeWidth-1:0]   be;
    logic [DataWidth-1:0] wdata;
  } bus_req_t;

  // Response, qualified by rvalid one cycle after the grant
  typedef struct packed {
    logic [DataWidth-1:0] rdata;
    logic                 err;
  } bus_rsp_t;

endpackage

`default_nettype wire

// ==== design/soc_map_pkg.sv ====
// ######################################
// Device indices, address map and
// register offsets of the devices
// ######################################

`default_nettype none

package soc_map_pkg;

  typedef enum logic [1:0] {
    DevRam,
    DevSimCtrl,
    DevTimer
  } device_e;

  localparam int NrDevices = 3;

  // 1 MB of RAM
  localparam logic [31:0] RamBase     = 32'h0010_0000;
  localparam logic [31:0] RamMask     = ~32'h000F_FFFF;

  // 1 kB register windows
  localparam logic [31:0] SimCtrlBase = 32'h0002_0000;
  localparam logic [31:0] SimCtrlMask = ~32'h0000_03FF;
  localparam logic [31:0] TimerBase   = 32'h0003_0000;
  localparam logic [31:0] TimerMask   = ~32'h0000_03FF;

  // Simulation control registers
  localparam logic [31:0] SimCtrlOutOffs  = 32'h0;
  localparam logic [31:0] SimCtrlHaltOffs = 32'h8;

  // Timer registers, each 64-bit value split in two words
  localparam logic [31:0] TimerMtimeLoOffs = 32'h0;
  localparam logic [31:0] TimerMtimeHiOffs = 32'h4;
  localparam logic [31:0] TimerCmpLoOffs   = 32'h8;
  localparam logic [31:0] TimerCmpHiOffs   = 32'hC;

endpackage

`default_nettype wire

// ==== design/bus_decoder.sv ====
// ######################################
// Address decoder with response mux
// and error reply for unmapped space
// ######################################

`timescale 1ns/1ps
`default_nettype none

module bus_decoder import bus_pkg::*, soc_map_pkg::*; (
  input  logic                 clk_i,
  input  logic                 rst_n_i,

  // Host side
  input  logic                 req_i,
  input  bus_req_t             host_req_i,
  output logic                 gnt_o,
  output logic                 rvalid_o,
  output bus_rsp_t             host_rsp_o,

  // Device side
  output logic [NrDevices-1:0] dev_req_o,
  output bus_req_t             dev_req_bus_o [NrDevices],
  input  logic [NrDevices-1:0] dev_rvalid_i,
  input  bus_rsp_t             dev_rsp_i [NrDevices]
);

  localparam bus_rsp_t UnmappedRsp = '{rdata: '0, err: 1'b1};

  logic    dev_hit;
  device_e dev_sel;

  logic    rvalid_q;
  logic    unmapped_q;
  device_e sel_q;

  // True if addr falls into the window of dev
  function automatic logic addr_hit(logic [AddrWidth-1:0] addr, device_e dev);
    logic hit;
    case (dev)
      DevRam:     hit = (addr & RamMask) == RamBase;
      DevSimCtrl: hit = (addr & SimCtrlMask) == SimCtrlBase;
      DevTimer:   hit = (addr & TimerMask) == TimerBase;
      default:    hit = 1'b0;
    endcase
    return hit;
  endfunction

  // First matching window wins, regions do not overlap anyway
  always_comb begin
    dev_hit = 1'b0;
    dev_sel = DevRam;
    for (int i = 0; i < NrDevices; i++) begin
      if (!dev_hit && addr_hit(host_req_i.addr, device_e'(i))) begin
        dev_hit = 1'b1;
        dev_sel = device_e'(i);
      end
    end
  end

  // Every device accepts a request each cycle
  assign gnt_o = req_i;

  always_comb begin
    for (int i = 0; i < NrDevices; i++) begin
      dev_req_o[i]     = req_i && dev_hit && (dev_sel == device_e'(i));
      dev_req_bus_o[i] = host_req_i;
    end
  end

  // Remember the target of the accepted request for the response
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q   <= 1'b0;
      unmapped_q <= 1'b0;
      sel_q      <= DevRam;
    end else begin
      rvalid_q <= req_i;
      if (req_i) begin
        unmapped_q <= !dev_hit;
        sel_q      <= dev_sel;
      end
    end
  end

  // Unmapped accesses are answered here, the rest by the device
  assign rvalid_o   = unmapped_q ? rvalid_q : dev_rvalid_i[sel_q];
  assign host_rsp_o = unmapped_q ? UnmappedRsp : dev_rsp_i[sel_q];

endmodule

`default_nettype wire

// ==== design/ram_1p.sv ====
// ######################################
// Single-port word RAM, byte enables
// ######################################

`timescale 1ns/1ps
`default_nettype none

module ram_1p import bus_pkg::*; #(
  parameter int RamDepth = 1024
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     req_i,
  input  bus_req_t req_bus_i,
  output logic     rvalid_o,
  output bus_rsp_t rsp_o
);

  localparam int IdxWidth = $clog2(RamDepth);

  logic [DataWidth-1:0] mem [RamDepth];
  logic [IdxWidth-1:0]  idx;
  logic [DataWidth-1:0] rdata_q;
  logic                 rvalid_q;

  // Word index, upper address bits are ignored so the RAM wraps
  assign idx = req_bus_i.addr[IdxWidth+1:2];

  always_ff @(posedge clk_i) begin
    if (req_i) begin
      if (req_bus_i.we) begin
        for (int b = 0; b < BeWidth; b++) begin
          if (req_bus_i.be[b]) begin
            mem[idx][b*8 +: 8] <= req_bus_i.wdata[b*8 +: 8];
          end
        end
        rdata_q <= '0;
      end else begin
        rdata_q <= mem[idx];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rsp_o    = '{rdata: rdata_q, err: 1'b0};

endmodule

`default_nettype wire

// ==== design/sim_ctrl.sv ====
// ######################################
// Simulation control, character output
// and halt register
// ######################################

`timescale 1ns/1ps
`default_nettype none

module sim_ctrl import bus_pkg::*, soc_map_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       req_i,
  input  bus_req_t   req_bus_i,
  output logic       rvalid_o,
  output bus_rsp_t   rsp_o,
  output logic       char_valid_o,
  output logic [7:0] char_o,
  output logic       halt_o
);

  logic [31:0] reg_offs;
  logic        wr;
  logic        out_wr;
  logic        halt_wr;

  logic        rvalid_q;
  logic        char_valid_q;
  logic        halt_q;
  logic [7:0]  char_q;

  // Word offset inside the 1 kB window
  assign reg_offs = req_bus_i.addr & ~SimCtrlMask & ~32'h3;

  assign wr      = req_i && req_bus_i.we;
  assign out_wr  = wr && (reg_offs == SimCtrlOutOffs) && req_bus_i.be[0];
  assign halt_wr = wr && (reg_offs == SimCtrlHaltOffs);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rvalid_q     <= 1'b0;
      char_valid_q <= 1'b0;
      halt_q       <= 1'b0;
    end else begin
      rvalid_q     <= req_i;
      char_valid_q <= out_wr;
      // Sticky until the next reset
      if (halt_wr) begin
        halt_q <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (out_wr) begin
      char_q <= req_bus_i.wdata[7:0];
    end
  end

  // Registers are write only
  assign rvalid_o     = rvalid_q;
  assign rsp_o        = '{rdata: '0, err: 1'b0};
  assign char_valid_o = char_valid_q;
  assign char_o       = char_q;
  assign halt_o       = halt_q;

endmodule

`default_nettype wire

// ==== design/timer.sv ====
// ######################################
// 64-bit mtime / mtimecmp timer with
// interrupt output
// ######################################

`timescale 1ns/1ps
`default_nettype none

module timer import bus_pkg::*, soc_map_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n_i,
  input  logic     req_i,
  input  bus_req_t req_bus_i,
  output logic     rvalid_o,
  output bus_rsp_t rsp_o,
  output logic     timer_irq_o
);

  logic [31:0]          reg_offs;
  logic                 wr;
  logic                 offs_ok;
  logic [DataWidth-1:0] rdata_d;
  logic [63:0]          mtime_d;
  logic [63:0]          mtimecmp_d;

  logic [63:0]          mtime_q;
  logic [63:0]          mtimecmp_q;
  logic                 rvalid_q;
  logic                 err_q;
  logic [DataWidth-1:0] rdata_q;

  // Merge the enabled bytes of wdata into old
  function automatic logic [31:0] merge_be(logic [31:0] old, logic [31:0] wdata,
                                           logic [BeWidth-1:0] be);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < BeWidth; b++) begin
      if (be[b]) begin
        res[b*8 +: 8] = wdata[b*8 +: 8];
      end
    end
    return res;
  endfunction

  assign reg_offs = req_bus_i.addr & ~TimerMask & ~32'h3;
  assign wr       = req_i && req_bus_i.we;

  // Read mux and offset check
  always_comb begin
    rdata_d = '0;
    offs_ok = 1'b1;
    case (reg_offs)
      TimerMtimeLoOffs: rdata_d = mtime_q[31:0];
      TimerMtimeHiOffs: rdata_d = mtime_q[63:32];
      TimerCmpLoOffs:   rdata_d = mtimecmp_q[31:0];
      TimerCmpHiOffs:   rdata_d = mtimecmp_q[63:32];
      default:          offs_ok = 1'b0;
    endcase
  end

  // A write to mtime replaces the increment of that cycle
  always_comb begin
    mtime_d    = mtime_q + 64'd1;
    mtimecmp_d = mtimecmp_q;
    if (wr) begin
      case (reg_offs)
        TimerMtimeLoOffs: mtime_d = {mtime_q[63:32],
                                     merge_be(mtime_q[31:0], req_bus_i.wdata, req_bus_i.be)};
        TimerMtimeHiOffs: mtime_d = {merge_be(mtime_q[63:32], req_bus_i.wdata, req_bus_i.be),
                                     mtime_q[31:0]};
        TimerCmpLoOffs:   mtimecmp_d[31:0] =
                            merge_be(mtimecmp_q[31:0], req_bus_i.wdata, req_bus_i.be);
        TimerCmpHiOffs:   mtimecmp_d[63:32] =
                            merge_be(mtimecmp_q[63:32], req_bus_i.wdata, req_bus_i.be);
        default: begin
        end
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      mtime_q    <= '0;
      mtimecmp_q <= '1;
      rvalid_q   <= 1'b0;
    end else begin
      mtime_q    <= mtime_d;
      mtimecmp_q <= mtimecmp_d;
      rvalid_q   <= req_i;
    end
  end

  // Read data holds the counter value seen at the accepting edge
  always_ff @(posedge clk_i) begin
    if (req_i) begin
      rdata_q <= req_bus_i.we ? '0 : rdata_d;
      err_q   <= !offs_ok;
    end
  end

  assign rvalid_o    = rvalid_q;
  assign rsp_o       = '{rdata: rdata_q, err: err_q};
  assign timer_irq_o = mtime_q >= mtimecmp_q;

endmodule

`default_nettype wire

// ==== design/simple_system.sv ====
// ######################################
// Top level, decoder plus RAM, sim
// control and timer devices
// ######################################

`timescale 1ns/1ps
`default_nettype none

module simple_system import bus_pkg::*, soc_map_pkg::*; #(
  parameter int RamDepth = 1024
) (
  input  logic       clk_i,
  input  logic       rst_n_i,

  // Data port of the host
  input  logic       req_i,
  input  bus_req_t   host_req_i,
  output logic       gnt_o,
  output logic       rvalid_o,
  output bus_rsp_t   host_rsp_o,

  output logic       char_valid_o,
  output logic [7:0] char_o,
  output logic       halt_o,
  output logic       timer_irq_o
);

  logic [NrDevices-1:0] dev_req;
  bus_req_t             dev_req_bus [NrDevices];
  logic [NrDevices-1:0] dev_rvalid;
  bus_rsp_t             dev_rsp [NrDevices];

  bus_decoder u_bus_decoder (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_i         (req_i),
    .host_req_i    (host_req_i),
    .gnt_o         (gnt_o),
    .rvalid_o      (rvalid_o),
    .host_rsp_o    (host_rsp_o),
    .dev_req_o     (dev_req),
    .dev_req_bus_o (dev_req_bus),
    .dev_rvalid_i  (dev_rvalid),
    .dev_rsp_i     (dev_rsp)
  );

  ram_1p #(
    .RamDepth (RamDepth)
  ) u_ram (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .req_i     (dev_req[DevRam]),
    .req_bus_i (dev_req_bus[DevRam]),
    .rvalid_o  (dev_rvalid[DevRam]),
    .rsp_o     (dev_rsp[DevRam])
  );

  sim_ctrl u_sim_ctrl (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_i        (dev_req[DevSimCtrl]),
    .req_bus_i    (dev_req_bus[DevSimCtrl]),
    .rvalid_o     (dev_rvalid[DevSimCtrl]),
    .rsp_o        (dev_rsp[DevSimCtrl]),
    .char_valid_o (char_valid_o),
    .char_o       (char_o),
    .halt_o       (halt_o)
  );

  timer u_timer (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .req_i       (dev_req[DevTimer]),
    .req_bus_i   (dev_req_bus[DevTimer]),
    .rvalid_o    (dev_rvalid[DevTimer]),
    .rsp_o       (dev_rsp[DevTimer]),
    .timer_irq_o (timer_irq_o)
  );

endmodule

`default_nettype wire

// ==== sim/tb_simple_system.sv ====
// ########################################
// Testbench with random bus traffic, a
// reference model and per-cycle checks
// ########################################

`timescale 1ns/1ps
`default_nettype none

module tb_simple_system import bus_pkg::*; ();

  localparam int RamDepth = 1024;
  localparam int NrWords  = 16;
  localparam int TgtRam   = 0;
  localparam int TgtSim   = 1;
  localparam int TgtTimer = 2;
  localparam int TgtNone  = 3;

  // Expected response of the request taken at the next edge
  typedef struct packed {
    logic        valid;
    logic [31:0] rdata;
    logic        err;
    logic        char_v;
  } expect_t;

  logic        clk_i;
  logic        rst_n_i;
  logic        req_i;
  bus_req_t    host_req_i;
  logic        gnt_o;
  logic        rvalid_o;
  bus_rsp_t    host_rsp_o;
  logic        char_valid_o;
  logic [7:0]  char_o;
  logic        halt_o;
  logic        timer_irq_o;

  // Reference model
  logic [31:0] ram_m [int unsigned];
  logic [7:0]  char_q [$];
  logic        halt_m;
  logic [63:0] mtime_m;
  logic [63:0] next_mtime;
  logic [63:0] cmp_m;
  expect_t     pend;

  int unsigned ram_idx [NrWords];
  int          errors = 0;
  int          checks = 0;
  int          timeouts = 0;

  simple_system #(.RamDepth(RamDepth)) i_simple_system (.*);

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Region of an address per the memory map
  function automatic int target_of(logic [31:0] addr);
    if ((addr & 32'hFFF0_0000) == 32'h0010_0000) return TgtRam;
    if ((addr & 32'hFFFF_FC00) == 32'h0002_0000) return TgtSim;
    if ((addr & 32'hFFFF_FC00) == 32'h0003_0000) return TgtTimer;
    return TgtNone;
  endfunction

  function automatic logic [31:0] apply_lanes(logic [31:0] old, logic [31:0] wdata,
                                              logic [3:0] be);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) res[b*8 +: 8] = wdata[b*8 +: 8];
    end
    return res;
  endfunction

  function automatic bus_req_t bus_request(logic [31:0] addr, logic we, logic [3:0] be,
                                           logic [31:0] wdata);
    bus_req_t r;
    r.addr  = addr;
    r.we    = we;
    r.be    = be;
    r.wdata = wdata;
    return r;
  endfunction

  // Random upper bits, the RAM wraps on the word index
  function automatic logic [31:0] ram_addr(int i);
    return 32'h0010_0000 | ($urandom & 32'h000F_F000) | (ram_idx[i] << 2);
  endfunction

  function automatic logic [31:0] unmapped_addr();
    logic [31:0] a;
    do a = $urandom; while (target_of(a) != TgtNone);
    return a;
  endfunction

  function automatic bus_req_t mixed_req();
    logic [31:0] addr;
    case ($urandom % 4)
      0:       addr = ram_addr($urandom % NrWords);
      1:       addr = 32'h0002_0000 + 4 * ($urandom % 4);
      2:       addr = 32'h0003_0000 + 4 * ($urandom % 8);
      default: addr = unmapped_addr();
    endcase
    return bus_request(addr, 1'($urandom), 4'($urandom), $urandom);
  endfunction

  task automatic compare(input string name, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("** Error at %0t: %s expected %0h, got %0h", $time, name, exp, act);
    end
  endtask

  // Update the model for a request that is taken at the next edge
  task automatic predict(input bus_req_t r);
    logic [31:0] offs;
    int unsigned idx;
    offs = r.addr & 32'h0000_03FC;
    idx  = (r.addr >> 2) % RamDepth;
    pend.valid = 1'b1;
    case (target_of(r.addr))
      TgtRam: begin
        if (r.we) begin
          ram_m[idx] = apply_lanes(ram_m.exists(idx) ? ram_m[idx] : '0, r.wdata, r.be);
        end else begin
          pend.rdata = ram_m[idx];
        end
      end
      TgtSim: begin
        if (r.we && offs == 32'h0 && r.be[0]) begin
          pend.char_v = 1'b1;
          char_q.push_back(r.wdata[7:0]);
        end
        if (r.we && offs == 32'h8) halt_m = 1'b1;
      end
      TgtTimer: begin
        case (offs)
          32'h0: begin
            pend.rdata = mtime_m[31:0];
            if (r.we) next_mtime = {mtime_m[63:32], apply_lanes(mtime_m[31:0], r.wdata, r.be)};
          end
          32'h4: begin
            pend.rdata = mtime_m[63:32];
            if (r.we) next_mtime = {apply_lanes(mtime_m[63:32], r.wdata, r.be), mtime_m[31:0]};
          end
          32'h8: begin
            pend.rdata = cmp_m[31:0];
            if (r.we) cmp_m[31:0] = apply_lanes(cmp_m[31:0], r.wdata, r.be);
          end
          32'hC: begin
            pend.rdata = cmp_m[63:32];
            if (r.we) cmp_m[63:32] = apply_lanes(cmp_m[63:32], r.wdata, r.be);
          end
          default: pend.err = 1'b1;
        endcase
        if (r.we) pend.rdata = '0;
      end
      default: pend.err = 1'b1;
    endcase
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk_i) begin
    if (!rst_n_i) begin
      pend    = '0;
      halt_m  = 1'b0;
      mtime_m = '0;
      cmp_m   = '1;
    end else begin
      compare("gnt_o", 64'(req_i), 64'(gnt_o));
      compare("rvalid_o", 64'(pend.valid), 64'(rvalid_o));
      if (pend.valid) begin
        compare("host_rsp_o.rdata", 64'(pend.rdata), 64'(host_rsp_o.rdata));
        compare("host_rsp_o.err", 64'(pend.err), 64'(host_rsp_o.err));
      end
      compare("char_valid_o", 64'(pend.char_v), 64'(char_valid_o));
      if (char_valid_o && char_q.size() > 0) begin
        compare("char_o", 64'(char_q.pop_front()), 64'(char_o));
      end
      compare("halt_o", 64'(halt_m), 64'(halt_o));
      compare("timer_irq_o", 64'(mtime_m >= cmp_m), 64'(timer_irq_o));
      pend       = '0;
      next_mtime = mtime_m + 64'd1;
      if (req_i) predict(host_req_i);
      mtime_m = next_mtime;
    end
  end

  task automatic drive(input bus_req_t r);
    @(posedge clk_i);
    req_i      <= 1'b1;
    host_req_i <= r;
  endtask

  task automatic release_bus();
    @(posedge clk_i);
    req_i      <= 1'b0;
    host_req_i <= '0;
  endtask

  task automatic wait_rvalid(output bus_rsp_t rsp);
    int n;
    n = 0;
    @(negedge clk_i);
    while (!rvalid_o && n < 8) begin
      @(negedge clk_i);
      n++;
    end
    if (!rvalid_o) begin
      timeouts++;
      $display("Timeout at %0t: the DUT gave no response to a request", $time);
    end
    rsp = host_rsp_o;
  endtask

  task automatic access(input bus_req_t r, output bus_rsp_t rsp);
    drive(r);
    release_bus();
    wait_rvalid(rsp);
  endtask

  initial begin
    bus_rsp_t    rsp;
    logic [31:0] target;
    int          n;
    rst_n_i    = 1'b0;
    req_i      = 1'b0;
    host_req_i = '0;
    void'($urandom(32'h1085));
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;

    // Full words first, then partial writes and reads
    for (int i = 0; i < NrWords; i++) begin
      ram_idx[i] = $urandom % RamDepth;
      access(bus_request(ram_addr(i), 1'b1, 4'hF, $urandom), rsp);
    end
    repeat (40) begin
      access(bus_request(ram_addr($urandom % NrWords), 1'b1, 4'($urandom), $urandom), rsp);
    end
    for (int i = 0; i < NrWords; i++) begin
      access(bus_request(ram_addr(i), 1'b0, 4'hF, '0), rsp);
    end
    repeat (20) access(bus_request(unmapped_addr(), 1'($urandom), 4'hF, $urandom), rsp);

    // Characters, then halt
    repeat (8) access(bus_request(32'h0002_0000, 1'b1, 4'($urandom), $urandom), rsp);
    access(bus_request(32'h0002_0008, 1'b1, 4'hF, 32'h1), rsp);
    access(bus_request(32'h0002_0004, 1'b1, 4'hF, 32'h1), rsp);

    // Compare value a little ahead of mtime
    access(bus_request(32'h0003_0000, 1'b0, 4'hF, '0), rsp);
    target = rsp.rdata + 20 + ($urandom % 20);
    access(bus_request(32'h0003_0008, 1'b1, 4'hF, target), rsp);
    access(bus_request(32'h0003_000C, 1'b1, 4'hF, 32'h0), rsp);
    n = 0;
    while (!timer_irq_o && n < 200) begin
      @(negedge clk_i);
      n++;
    end
    if (!timer_irq_o) begin
      timeouts++;
      $display("Timeout at %0t: the timer interrupt never rose", $time);
    end
    repeat (10) access(bus_request(32'h0003_0010 + 4 * ($urandom % 252), 1'($urandom), 4'hF,
                                   $urandom), rsp);

    // Back-to-back mixed traffic
    repeat (200) drive(mixed_req());
    release_bus();
    wait_rvalid(rsp);
    @(posedge clk_i);
    if (char_q.size() != 0) begin
      errors++;
      $display("%0d expected characters never appeared on char_o", char_q.size());
    end
    $display("Checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
design/bus_pkg.sv
design/soc_map_pkg.sv
design/bus_decoder.sv
design/ram_1p.sv
design/sim_ctrl.sv
design/timer.sv
design/simple_system.sv
sim/tb_simple_system.sv

// ==== Makefile ====
# Verilator lint, simulation and clean rules for simple_system

TOP = tb_simple_system

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module simple_system \
		design/bus_pkg.sv design/soc_map_pkg.sv design/bus_decoder.sv \
		design/ram_1p.sv design/sim_ctrl.sv design/timer.sv design/simple_system.sv
	verilator --lint-only --timing --top-module $(TOP) -f sources.f

sim:
	verilator --binary --timing --top-module $(TOP) -f sources.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -qx "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log
